//--- conv.f
+incdir+.
hdl/conv_types_pkg.sv
hdl/conv_ctrl_pkg.sv
hdl/conv_mac.sv
hdl/conv_maxpool.sv
hdl/conv_layer.sv
verif/conv_layer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the conv_layer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f conv.f --top-module conv_layer_tb -o conv_layer_sim

./obj_dir/conv_layer_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
else
	exit 1
fi

//--- verif/conv_layer_tb.sv
`default_nettype none
`include "conv_settings.svh"

module conv_layer_tb import conv_types_pkg::*, conv_ctrl_pkg::*;;

	localparam int IMG_WORDS  = `CONV_IMG_DIM * `CONV_IMG_DIM;
	localparam int POOL_WORDS = `CONV_POOL_DIM * `CONV_POOL_DIM;
	// 13 cycles per layer-0 pixel, 7 per pool window, plus start and drain
	localparam int RUN_CYCLES = IMG_WORDS * 13 + 2 * POOL_WORDS * 7 + 20;
	localparam int MAX_CYCLES = 4 * RUN_CYCLES + 30000;

	// Kernel weights, raster order over the 3x3 window
	localparam pixel_t K0_W [0:8] = '{20'h0A89E, 20'h092D5, 20'h06D43, 20'h01004,
		20'hF8F71, 20'hF6E54, 20'hFA6D7, 20'hFC834, 20'hFAC19};
	localparam pixel_t K1_W [0:8] = '{20'hFDB55, 20'h02992, 20'hFC994, 20'h050FD,
		20'h02F20, 20'h0202D, 20'h03BD7, 20'hFD369, 20'h05E68};

	logic      clk;
	logic      reset;
	logic      ready;
	logic      busy;
	mem_addr_t iaddr;
	pixel_t    idata = '0;
	logic      cwr;
	mem_addr_t caddr_wr;
	pixel_t    cdata_wr;
	logic      crd;
	mem_addr_t caddr_rd;
	pixel_t    cdata_rd = '0;
	mem_sel_t  csel;

	pixel_t    img [0:IMG_WORDS-1];
	pixel_t    res_mem [0:7][0:IMG_WORDS-1];	// Indexed by csel
	pixel_t    exp_l0 [0:1][0:IMG_WORDS-1];
	pixel_t    exp_l1 [0:1][0:POOL_WORDS-1];
	mem_addr_t img_addr_q = '0;
	mem_addr_t rd_addr_q = '0;
	logic [2:0] rd_sel_q = '0;
	int        bad_sel_writes = 0;
	int        cycle_count = 0;
	int        value_errors;
	int        other_errors;
	integer    seed;

	conv_layer conv_layer_inst (
		.clk      (clk),
		.reset    (reset),
		.ready    (ready),
		.busy     (busy),
		.iaddr    (iaddr),
		.idata    (idata),
		.cwr      (cwr),
		.caddr_wr (caddr_wr),
		.cdata_wr (cdata_wr),
		.crd      (crd),
		.caddr_rd (caddr_rd),
		.cdata_rd (cdata_rd),
		.csel     (csel)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Memories sample on the rising edge, read data shows up at the falling edge
	always @(posedge clk) begin
		if (cwr) begin
			if (csel == SEL_NONE || csel > SEL_L1_K1)
				bad_sel_writes <= bad_sel_writes + 1;
			else
				res_mem[csel][caddr_wr] <= cdata_wr;
		end
		if (crd) begin
			rd_sel_q  <= csel;
			rd_addr_q <= caddr_rd;
		end
		img_addr_q <= iaddr;
	end

	always @(negedge clk) begin
		idata    <= img[img_addr_q];
		cdata_rd <= res_mem[rd_sel_q][rd_addr_q];
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, busy never fell", cycle_count);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic pixel_t round_relu(input logic signed [63:0] acc, input pixel_t bias);
		logic signed [63:0] b;
		logic signed [63:0] s;
		b = bias;
		s = acc + b * 65536 + 64'sd32768;
		if (s < 0)
			return '0;
		return s[35:16];
	endfunction

	task automatic compute_model();
		logic signed [63:0] acc0;
		logic signed [63:0] acc1;
		pixel_t m;
		pixel_t v;
		int r, c, t, rr, cc, k, i, base;
		for (r = 0; r < `CONV_IMG_DIM; r++) begin
			for (c = 0; c < `CONV_IMG_DIM; c++) begin
				acc0 = 0;
				acc1 = 0;
				for (t = 0; t < `CONV_TAPS; t++) begin
					rr = r + t / 3 - 1;
					cc = c + t % 3 - 1;
					if (rr >= 0 && rr < `CONV_IMG_DIM && cc >= 0 && cc < `CONV_IMG_DIM) begin
						acc0 = acc0 + img[rr * `CONV_IMG_DIM + cc] * K0_W[t];
						acc1 = acc1 + img[rr * `CONV_IMG_DIM + cc] * K1_W[t];
					end
				end
				exp_l0[0][r * `CONV_IMG_DIM + c] = round_relu(acc0, `CONV_BIAS0);
				exp_l0[1][r * `CONV_IMG_DIM + c] = round_relu(acc1, `CONV_BIAS1);
			end
		end
		for (k = 0; k < 2; k++) begin
			for (r = 0; r < `CONV_POOL_DIM; r++) begin
				for (c = 0; c < `CONV_POOL_DIM; c++) begin
					base = 2 * r * `CONV_IMG_DIM + 2 * c;
					m = '0;
					for (i = 0; i < 4; i++) begin
						v = exp_l0[k][base + (i / 2) * `CONV_IMG_DIM + i % 2];
						if (i == 0 || v > m)
							m = v;
					end
					exp_l1[k][r * `CONV_POOL_DIM + c] = m;
				end
			end
		end
	endtask

	// Stale pattern so a missing write shows up
	task automatic preset_results();
		int s, a;
		for (s = 1; s <= 4; s++)
			for (a = 0; a < IMG_WORDS; a++)
				res_mem[s][a] = {s[3:0], 4'h5, a[11:0]};
	endtask

	task automatic run_image();
		int bad_before;
		bad_before = bad_sel_writes;
		@(negedge clk);
		if (busy) begin
			other_errors++;
			$display("busy was already high before ready was raised");
		end
		ready = 1'b1;
		@(negedge clk);
		if (!busy) begin
			other_errors++;
			$display("busy did not rise one cycle after ready");
		end
		ready = 1'b0;
		while (busy)
			@(negedge clk);
		repeat (2) @(negedge clk);
		if (bad_sel_writes != bad_before) begin
			other_errors++;
			$display("%0d writes went to SEL_NONE or an unknown memory",
				bad_sel_writes - bad_before);
		end
	endtask

	task automatic compare_layers();
		int k, a;
		for (k = 0; k < 2; k++) begin
			for (a = 0; a < IMG_WORDS; a++)
				if (res_mem[k + 1][a] !== exp_l0[k][a]) begin
					value_errors++;
					$display("Fail l0_k%0d[0x%03h]: expected 0x%05h, got 0x%05h",
						k, a, exp_l0[k][a], res_mem[k + 1][a]);
				end
			for (a = 0; a < POOL_WORDS; a++)
				if (res_mem[k + 3][a] !== exp_l1[k][a]) begin
					value_errors++;
					$display("Fail l1_k%0d[0x%03h]: expected 0x%05h, got 0x%05h",
						k, a, exp_l1[k][a], res_mem[k + 3][a]);
				end
		end
	endtask

	task automatic fill_random_image();
		logic [31:0] rnd;
		int a;
		for (a = 0; a < IMG_WORDS; a++) begin
			rnd = $random(seed);
			img[a] = {{2{rnd[17]}}, rnd[17:0]};	// Roughly -2.0 to 2.0
		end
	endtask

	task automatic test_reset_state();
		repeat (5) begin
			@(negedge clk);
			if (busy || cwr || crd || csel != SEL_NONE) begin
				value_errors++;
				$display("Fail reset state: busy=0x%h cwr=0x%h crd=0x%h csel=0x%h",
					busy, cwr, crd, csel);
			end
		end
	endtask

	task automatic test_random_image();
		fill_random_image();
		compute_model();
		preset_results();
		run_image();
		compare_layers();
	endtask

	// Border pixels lose the masked taps, so they differ from the interior
	task automatic test_constant_image();
		int a;
		for (a = 0; a < IMG_WORDS; a++)
			img[a] = 20'h10000;
		compute_model();
		preset_results();
		run_image();
		compare_layers();
	endtask

	task automatic test_negative_image();
		logic [31:0] rnd;
		int a, k;
		for (a = 0; a < IMG_WORDS; a++) begin
			rnd = $random(seed);
			img[a] = {3'b111, rnd[16:0]};
		end
		compute_model();
		preset_results();
		run_image();
		compare_layers();
		for (k = 1; k <= 2; k++)
			for (a = 0; a < IMG_WORDS; a++)
				if (res_mem[k][a] < 0) begin
					value_errors++;
					$display("Fail l0_k%0d[0x%03h] negative after ReLU: got 0x%05h",
						k - 1, a, res_mem[k][a]);
				end
	endtask

	initial begin
		seed = 26410;
		value_errors = 0;
		other_errors = 0;
		ready = 1'b0;
		reset = 1'b1;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		test_reset_state();
		test_random_image();
		test_constant_image();
		test_negative_image();
		test_random_image();	// Restart without reset

		$display("Errors: %0d value mismatches, %0d protocol errors",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/conv_layer.sv
`default_nettype none
`include "conv_settings.svh"

module conv_layer import conv_types_pkg::*, conv_ctrl_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	input  wire        ready,
	output logic       busy,
	output mem_addr_t  iaddr,
	input  wire pixel_t idata,
	output logic       cwr,
	output mem_addr_t  caddr_wr,
	output pixel_t     cdata_wr,
	output logic       crd,
	output mem_addr_t  caddr_rd,
	input  wire pixel_t cdata_rd,
	output mem_sel_t   csel
);

	phase_t     phase;
	mem_addr_t  pix;	// Layer-0 scan, row in the upper half
	logic       pix_last;
	logic [10:0] pool_idx;	// Kernel, row, col
	logic       pool_last;
	logic       mac_start;
	logic       mac_done;
	pixel_t     mac_r0;
	pixel_t     mac_r1;
	logic       pool_start;
	logic       pool_done;
	pixel_t     pool_out;
	mem_req_t   pool_req;
	mem_req_t   req_next;
	pixel_t     res0;
	pixel_t     res1;
	pixel_t     pool_max;
	mem_addr_t  out_addr;
	mem_sel_t   out_sel;

	assign mac_start  = (phase == PH_IDLE && ready) || (phase == PH_WR_K1 && !pix_last);
	assign pool_start = (phase == PH_WR_K1 && pix_last) ||
		(phase == PH_POOL_WR && !pool_last);

	conv_mac mac_inst (
		.clk     (clk),
		.reset   (reset),
		.start   (mac_start),
		.row     (pix[11:6]),
		.col     (pix[5:0]),
		.iaddr   (iaddr),
		.idata   (idata),
		.done    (mac_done),
		.result0 (mac_r0),
		.result1 (mac_r1)
	);

	conv_maxpool pool_inst (
		.clk        (clk),
		.reset      (reset),
		.start      (pool_start),
		.kernel_sel (pool_idx[10]),
		.row        (coord_t'(pool_idx[9:5])),
		.col        (coord_t'(pool_idx[4:0])),
		.req        (pool_req),
		.cdata_rd   (cdata_rd),
		.done       (pool_done),
		.max_out    (pool_out)
	);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase     <= PH_IDLE;
			busy      <= 1'b0;
			pix       <= '0;
			pix_last  <= 1'b0;
			pool_idx  <= '0;
			pool_last <= 1'b0;
		end else begin
			case (phase)
				PH_IDLE: if (ready) begin
					phase <= PH_CONV;
					busy  <= 1'b1;
				end
				PH_CONV: if (mac_done) begin
					phase    <= PH_WR_K0;
					pix      <= pix + 1'b1;	// Wraps to 0 after the last pixel
					pix_last <= pix == mem_addr_t'(`CONV_IMG_DIM * `CONV_IMG_DIM - 1);
				end
				PH_WR_K0: phase <= PH_WR_K1;
				PH_WR_K1: phase <= pix_last ? PH_POOL : PH_CONV;
				PH_POOL: if (pool_done) begin
					phase     <= PH_POOL_WR;
					pool_idx  <= pool_idx + 1'b1;
					pool_last <= pool_idx == 11'(2 * `CONV_POOL_DIM * `CONV_POOL_DIM - 1);
				end
				PH_POOL_WR: phase <= pool_last ? PH_DONE : PH_POOL;
				PH_DONE: begin
					phase     <= PH_IDLE;
					busy      <= 1'b0;
					pix_last  <= 1'b0;
					pool_last <= 1'b0;
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	// Results held for the write states
	always_ff @(posedge clk) begin
		if (phase == PH_CONV && mac_done) begin
			res0     <= mac_r0;
			res1     <= mac_r1;
			out_addr <= pix;
		end
		if (phase == PH_POOL && pool_done) begin
			pool_max <= pool_out;
			out_addr <= mem_addr_t'(pool_idx[9:0]);
			out_sel  <= pool_idx[10] ? SEL_L1_K1 : SEL_L1_K0;
		end
	end

	// Pool reads and our writes never share a cycle
	always_comb begin
		req_next = pool_req;
		if (phase == PH_WR_K0 || phase == PH_WR_K1 || phase == PH_POOL_WR) begin
			req_next.wr   = 1'b1;
			req_next.rd   = 1'b0;
			req_next.addr = out_addr;
			case (phase)
				PH_WR_K0: begin
					req_next.sel   = SEL_L0_K0;
					req_next.wdata = res0;
				end
				PH_WR_K1: begin
					req_next.sel   = SEL_L0_K1;
					req_next.wdata = res1;
				end
				default: begin
					req_next.sel   = out_sel;
					req_next.wdata = pool_max;
				end
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cwr  <= 1'b0;
			crd  <= 1'b0;
			csel <= SEL_NONE;
		end else begin
			cwr  <= req_next.wr;
			crd  <= req_next.rd;
			csel <= req_next.sel;
		end
	end

	always_ff @(posedge clk) begin
		caddr_wr <= req_next.addr;
		caddr_rd <= req_next.addr;
		cdata_wr <= req_next.wdata;
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (reset) !(cwr && crd));

	a_sel_valid: assert property (@(posedge clk) disable iff (reset)
		(cwr || crd) |-> csel != SEL_NONE);

endmodule

`default_nettype wire

//--- hdl/conv_maxpool.sv
`default_nettype none

module conv_maxpool import conv_types_pkg::*, conv_ctrl_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	input  wire        start,
	input  wire        kernel_sel,
	input  wire coord_t row,
	input  wire coord_t col,
	output mem_req_t   req,
	input  wire pixel_t cdata_rd,
	output logic       done,
	output pixel_t     max_out
);

	logic [2:0] step;	// Reads in 1..4, data back in 3..6
	logic [1:0] rd_idx;
	logic       k_q;
	coord_t     row_q;
	coord_t     col_q;
	pixel_t     run_max;

	assign rd_idx = 2'(step - 3'd1);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			step <= '0;
		end else if (start) begin
			step <= 3'd1;
		end else if (step == 3'd6) begin
			step <= '0;
		end else if (step != '0) begin
			step <= step + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			k_q   <= kernel_sel;
			row_q <= row;
			col_q <= col;
		end
		if (step == 3'd3)
			run_max <= cdata_rd;	// First value of the window
		else if (step == 3'd4 || step == 3'd5)
			run_max <= max_out;
	end

	// TL, TR, BL, BR of the 2x2 window in layer 0
	always_comb begin
		req = '0;
		if (step >= 3'd1 && step <= 3'd4) begin
			req.rd   = 1'b1;
			req.sel  = k_q ? SEL_L0_K1 : SEL_L0_K0;
			req.addr = {row_q[4:0], rd_idx[1], col_q[4:0], rd_idx[0]};
		end
	end

	assign max_out = (cdata_rd > run_max) ? cdata_rd : run_max;
	assign done    = step == 3'd6;

	a_no_write: assert property (@(posedge clk) disable iff (reset) !req.wr);

	a_read_burst: assert property (@(posedge clk) disable iff (reset)
		start |=> req.rd [*4] ##2 done);

endmodule

`default_nettype wire

//--- hdl/conv_mac.sv
`default_nettype none
`include "conv_settings.svh"

module conv_mac import conv_types_pkg::*; (
	input  wire       clk,
	input  wire       reset,
	input  wire       start,
	input  wire coord_t row,
	input  wire coord_t col,
	output mem_addr_t iaddr,
	input  wire pixel_t idata,
	output logic      done,
	output pixel_t    result0,
	output pixel_t    result1
);

	logic [3:0] step;	// 1..9 address taps, 2..10 data taps
	logic [3:0] addr_tap;
	logic [3:0] data_tap;
	logic       acc_en;
	logic [8:0] mask;
	coord_t     row_q;
	coord_t     col_q;
	logic       top_ok;
	logic       bot_ok;
	logic       left_ok;
	logic       right_ok;
	pixel_t     w0;
	pixel_t     w1;
	prod_t      prod0;
	prod_t      prod1;
	acc_t       acc0;
	acc_t       acc1;

	// Kernel weight tables, raster order over the window
	function automatic pixel_t weight(input logic k, input logic [3:0] t);
		case ({k, t})
			5'h00: return 20'h0A89E;
			5'h01: return 20'h092D5;
			5'h02: return 20'h06D43;
			5'h03: return 20'h01004;
			5'h04: return 20'hF8F71;
			5'h05: return 20'hF6E54;
			5'h06: return 20'hFA6D7;
			5'h07: return 20'hFC834;
			5'h08: return 20'hFAC19;
			5'h10: return 20'hFDB55;
			5'h11: return 20'h02992;
			5'h12: return 20'hFC994;
			5'h13: return 20'h050FD;
			5'h14: return 20'h02F20;
			5'h15: return 20'h0202D;
			5'h16: return 20'h03BD7;
			5'h17: return 20'hFD369;
			5'h18: return 20'h05E68;
			default: return '0;
		endcase
	endfunction

	// Neighbour address, wraps at the border and gets masked later
	function automatic mem_addr_t tap_addr(input coord_t r, input coord_t c,
		input logic [3:0] t);
		coord_t dr;
		coord_t dc;
		dr = (t >= 4'd6) ? 6'd2 : (t >= 4'd3) ? 6'd1 : 6'd0;
		dc = coord_t'(t) - 6'd3 * dr;
		return {coord_t'(r + dr - 6'd1), coord_t'(c + dc - 6'd1)};
	endfunction

	// Bias, round half up, take Q4.16 slice, ReLU
	function automatic pixel_t finish(input acc_t acc, input pixel_t bias);
		acc_t sum;
		sum = acc + (acc_t'(bias) <<< `CONV_FRAC_BITS)
			+ (acc_t'(1) <<< (`CONV_FRAC_BITS - 1));
		return (sum < 0) ? pixel_t'(0) : sum[`CONV_FRAC_BITS+19:`CONV_FRAC_BITS];
	endfunction

	assign addr_tap = step - 4'd1;
	assign data_tap = step - 4'd2;
	assign acc_en   = (step >= 4'd2) && (step <= 4'(`CONV_TAPS + 1));

	assign iaddr = tap_addr(row_q, col_q, addr_tap);

	// Which sides of the window fall inside the image
	assign top_ok   = row != '0;
	assign bot_ok   = row != coord_t'(`CONV_IMG_DIM - 1);
	assign left_ok  = col != '0;
	assign right_ok = col != coord_t'(`CONV_IMG_DIM - 1);

	assign w0    = weight(1'b0, data_tap);
	assign w1    = weight(1'b1, data_tap);
	assign prod0 = idata * w0;
	assign prod1 = idata * w1;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			step <= '0;
		end else if (start) begin
			step <= 4'd1;
		end else if (step == 4'(`CONV_TAPS + 2)) begin
			step <= '0;
		end else if (step != '0) begin
			step <= step + 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			row_q <= row;
			col_q <= col;
			mask  <= {bot_ok & right_ok, bot_ok, bot_ok & left_ok,
				right_ok, 1'b1, left_ok,
				top_ok & right_ok, top_ok, top_ok & left_ok};
			acc0  <= '0;
			acc1  <= '0;
		end else if (acc_en && mask[data_tap]) begin
			acc0 <= acc0 + prod0;
			acc1 <= acc1 + prod1;
		end
	end

	assign done    = step == 4'(`CONV_TAPS + 2);
	assign result0 = finish(acc0, `CONV_BIAS0);
	assign result1 = finish(acc1, `CONV_BIAS1);

	a_done_pulse: assert property (@(posedge clk) disable iff (reset)
		done |=> !done);

	// Fixed latency the top level counts on
	a_done_latency: assert property (@(posedge clk) disable iff (reset)
		start |-> ##(`CONV_TAPS + 2) done);

endmodule

`default_nettype wire

//--- hdl/conv_ctrl_pkg.sv
`default_nettype none

package conv_ctrl_pkg;
	import conv_types_pkg::*;

	// Layer memory chosen by csel
	typedef enum logic [2:0] {
		SEL_NONE  = 3'd0,
		SEL_L0_K0 = 3'd1,
		SEL_L0_K1 = 3'd2,
		SEL_L1_K0 = 3'd3,
		SEL_L1_K1 = 3'd4
	} mem_sel_t;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_CONV,
		PH_WR_K0,
		PH_WR_K1,
		PH_POOL,
		PH_POOL_WR,
		PH_DONE
	} phase_t;

	// One request on the layer memory port
	typedef struct packed {
		logic      wr;
		logic      rd;
		mem_sel_t  sel;
		mem_addr_t addr;
		pixel_t    wdata;
	} mem_req_t;

endpackage

`default_nettype wire

//--- hdl/conv_types_pkg.sv
`default_nettype none
`include "conv_settings.svh"

package conv_types_pkg;

	// Q4.16 image and layer data
	typedef logic signed [19:0] pixel_t;

	typedef logic signed [39:0] prod_t;	// Pixel times weight
	typedef logic signed [43:0] acc_t;	// Nine products plus headroom

	// Row or column inside the 64x64 image
	typedef logic [$clog2(`CONV_IMG_DIM)-1:0] coord_t;

	// Layer 0 is row*64+col, layer 1 is row*32+col
	typedef logic [2*$clog2(`CONV_IMG_DIM)-1:0] mem_addr_t;

endpackage

`default_nettype wire

//--- conv_settings.svh
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// Image and pooled layer geometry
`define CONV_IMG_DIM    64
`define CONV_POOL_DIM   32

// Q4.16 fixed point
`define CONV_FRAC_BITS  16

// Per-kernel bias, same Q4.16 format as the pixels
`define CONV_BIAS0      20'h01310
`define CONV_BIAS1      20'hF7295

// 3x3 window
`define CONV_TAPS       9

`endif
